// ==== include/convAccel_settings.svh ====
`ifndef CONV_ACCEL_SETTINGS_SVH
`define CONV_ACCEL_SETTINGS_SVH

// Bits per matrix element
`define CONV_SAMPLE_WIDTH 16

// Accumulator and result width
`define CONV_ACC_WIDTH 40

// Largest row or column count of either matrix
`define CONV_MAX_DIM 64

// Elements held by each operand memory
`define CONV_MEM_DEPTH 4096

// Element address width, log2 of the memory depth
`define CONV_ADDR_WIDTH 12

// Result FIFO entries
`define CONV_FIFO_DEPTH 16

`endif

// ==== verilog/convGeometryPkg.sv ====
`default_nettype none

`include "convAccel_settings.svh"

package convGeometryPkg;

    // Row or column count, wide enough to hold CONV_MAX_DIM itself
    typedef logic [$clog2(`CONV_MAX_DIM):0] dimT;

    // Element address inside one operand memory
    typedef logic [`CONV_ADDR_WIDTH-1:0] elemAddrT;

    // Host address, top bit selects data (0) or filter (1)
    typedef logic [`CONV_ADDR_WIDTH:0] hostAddrT;

    // Window sequencer states
    typedef enum logic [1:0] {
        IDLE,
        INIT,
        CALC
    } seqStateT;

endpackage

`default_nettype wire

// ==== verilog/convArithPkg.sv ====
`default_nettype none

`include "convAccel_settings.svh"

package convArithPkg;

    // One signed matrix element
    typedef logic signed [`CONV_SAMPLE_WIDTH-1:0] sampleT;

    // Full-precision element product
    typedef logic signed [2*`CONV_SAMPLE_WIDTH-1:0] productT;

    // Running dot product, wraps on overflow
    typedef logic signed [`CONV_ACC_WIDTH-1:0] accT;

endpackage

`default_nettype wire

// ==== verilog/convIfs.sv ====
`default_nettype none

`include "convAccel_settings.svh"

// Read requests from the window sequencer to the operand memories
interface opReadIf;
    import convGeometryPkg::*;

    logic     readEn;
    elemAddrT dataAddr;
    elemAddrT filtAddr;
    logic     last;

    modport seq (
        output readEn,
        output dataAddr,
        output filtAddr,
        output last
    );

    modport store (
        input readEn,
        input dataAddr,
        input filtAddr,
        input last
    );

endinterface

// Operand pairs from the memories to the MAC, one cycle behind the read
interface operandIf;
    import convArithPkg::*;

    sampleT dataVal;
    sampleT filtVal;
    logic   valid;
    logic   last;

    modport src (
        output dataVal,
        output filtVal,
        output valid,
        output last
    );

    modport sink (
        input dataVal,
        input filtVal,
        input valid,
        input last
    );

endinterface

`default_nettype wire

// ==== verilog/operandStore.sv ====
`default_nettype none

`include "convAccel_settings.svh"

module operandStore (
    input  wire                            clkIn,
    input  wire convGeometryPkg::hostAddrT addrIn,
    input  wire                            wrEnIn,
    input  wire convArithPkg::sampleT      wrDataIn,
    opReadIf.store                         rd,
    operandIf.src                          op
);
    import convGeometryPkg::*;
    import convArithPkg::*;

    sampleT dataMem [`CONV_MEM_DEPTH];
    sampleT filtMem [`CONV_MEM_DEPTH];

    elemAddrT wrAddr;
    logic     wrFilt;

    sampleT dataQ;
    sampleT filtQ;
    logic   validQ;
    logic   lastQ;

    // Top host address bit picks the memory
    assign wrAddr = addrIn[`CONV_ADDR_WIDTH-1:0];
    assign wrFilt = addrIn[`CONV_ADDR_WIDTH];

    // Data memory, host write port and engine read port
    always_ff @(posedge clkIn) begin
        if (wrEnIn && !wrFilt) begin
            dataMem[wrAddr] <= wrDataIn;
        end
        if (rd.readEn) begin
            dataQ <= dataMem[rd.dataAddr];
        end
    end

    // Filter memory
    always_ff @(posedge clkIn) begin
        if (wrEnIn && wrFilt) begin
            filtMem[wrAddr] <= wrDataIn;
        end
        if (rd.readEn) begin
            filtQ <= filtMem[rd.filtAddr];
        end
    end

    // Strobes travel alongside the registered read data
    always_ff @(posedge clkIn) begin
        validQ <= rd.readEn;
        lastQ  <= rd.readEn & rd.last;
    end

    assign op.dataVal = dataQ;
    assign op.filtVal = filtQ;
    assign op.valid   = validQ;
    assign op.last    = lastQ;

endmodule

`default_nettype wire

// ==== verilog/windowSequencer.sv ====
`default_nettype none

`include "convAccel_settings.svh"

module windowSequencer (
    input  wire                       clkIn,
    input  wire                       rstIn,
    input  wire                       startIn,
    input  wire convGeometryPkg::dimT filtRowsIn,
    input  wire convGeometryPkg::dimT filtColsIn,
    input  wire convGeometryPkg::dimT dataRowsIn,
    input  wire convGeometryPkg::dimT dataColsIn,
    input  wire                       room,
    opReadIf.seq                      rd
);
    import convGeometryPkg::*;

    seqStateT stateQ;

    // Dimensions captured at start
    dimT filtRowsQ;
    dimT filtColsQ;
    dimT dataRowsQ;
    dimT dataColsQ;

    // Last index of each counter, set up in INIT
    dimT filtRowLastQ;
    dimT filtColLastQ;
    dimT outRowLastQ;
    dimT outColLastQ;

    // Nested index counters, filter column innermost
    dimT filtColQ;
    dimT filtRowQ;
    dimT outColQ;
    dimT outRowQ;

    logic issue;
    logic windowLast;
    logic runLast;

    elemAddrT dataRowIdx;
    elemAddrT dataColIdx;

    assign issue      = (stateQ == CALC) && room;
    assign windowLast = (filtColQ == filtColLastQ) && (filtRowQ == filtRowLastQ);
    assign runLast    = windowLast && (outColQ == outColLastQ) && (outRowQ == outRowLastQ);

    always_ff @(posedge clkIn) begin
        if (stateQ == IDLE && startIn) begin
            filtRowsQ <= filtRowsIn;
            filtColsQ <= filtColsIn;
            dataRowsQ <= dataRowsIn;
            dataColsQ <= dataColsIn;
        end
    end

    // Valid convolution extents
    always_ff @(posedge clkIn) begin
        if (stateQ == INIT) begin
            filtRowLastQ <= filtRowsQ - 1'b1;
            filtColLastQ <= filtColsQ - 1'b1;
            outRowLastQ  <= dataRowsQ - filtRowsQ;
            outColLastQ  <= dataColsQ - filtColsQ;
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            stateQ   <= IDLE;
            filtColQ <= '0;
            filtRowQ <= '0;
            outColQ  <= '0;
            outRowQ  <= '0;
        end else begin
            case (stateQ)
                IDLE: begin
                    if (startIn) begin
                        stateQ <= INIT;
                    end
                end
                INIT: begin
                    filtColQ <= '0;
                    filtRowQ <= '0;
                    outColQ  <= '0;
                    outRowQ  <= '0;
                    stateQ   <= CALC;
                end
                CALC: begin
                    // Counters hold while the FIFO lacks room
                    if (issue) begin
                        if (filtColQ != filtColLastQ) begin
                            filtColQ <= filtColQ + 1'b1;
                        end else begin
                            filtColQ <= '0;
                            if (filtRowQ != filtRowLastQ) begin
                                filtRowQ <= filtRowQ + 1'b1;
                            end else begin
                                filtRowQ <= '0;
                                if (outColQ != outColLastQ) begin
                                    outColQ <= outColQ + 1'b1;
                                end else begin
                                    outColQ <= '0;
                                    if (outRowQ != outRowLastQ) begin
                                        outRowQ <= outRowQ + 1'b1;
                                    end else begin
                                        outRowQ <= '0;
                                    end
                                end
                            end
                        end
                        if (runLast) begin
                            stateQ <= IDLE;
                        end
                    end
                end
                default: begin
                    stateQ <= IDLE;
                end
            endcase
        end
    end

    // Window origin plus filter offset, in data coordinates
    assign dataRowIdx = elemAddrT'(outRowQ) + elemAddrT'(filtRowQ);
    assign dataColIdx = elemAddrT'(outColQ) + elemAddrT'(filtColQ);

    assign rd.readEn   = issue;
    assign rd.dataAddr = dataRowIdx * elemAddrT'(dataColsQ) + dataColIdx;
    assign rd.filtAddr = elemAddrT'(filtRowQ) * elemAddrT'(filtColsQ) + elemAddrT'(filtColQ);
    assign rd.last     = windowLast;

endmodule

`default_nettype wire

// ==== verilog/macUnit.sv ====
`default_nettype none

`include "convAccel_settings.svh"

module macUnit (
    input  wire               clkIn,
    input  wire               rstIn,
    operandIf.sink            op,
    output logic              resultValid,
    output convArithPkg::accT result
);
    import convArithPkg::*;

    productT product;
    accT     sumQ;
    accT     sumNext;

    // Signed multiply, product sign-extended into the accumulator
    assign product = op.dataVal * op.filtVal;
    assign sumNext = sumQ + accT'(product);

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            sumQ        <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= op.valid & op.last;
            if (op.valid) begin
                // Next window starts from zero
                if (op.last) begin
                    sumQ <= '0;
                end else begin
                    sumQ <= sumNext;
                end
            end
        end
    end

    // Final sum of the window
    always_ff @(posedge clkIn) begin
        if (op.valid && op.last) begin
            result <= sumNext;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/resultFifo.sv ====
`default_nettype none

`include "convAccel_settings.svh"

module resultFifo (
    input  wire                     clkIn,
    input  wire                     rstIn,
    input  wire                     wrValid,
    input  wire convArithPkg::accT  wrData,
    output logic                    room,
    input  wire                     readyIn,
    output logic                    validOut,
    output convArithPkg::accT       dataOut
);
    import convArithPkg::*;

    localparam int ptrWidth = $clog2(`CONV_FIFO_DEPTH);

    localparam logic [ptrWidth:0] fifoDepth = `CONV_FIFO_DEPTH;

    // Results that can still be on their way after room is sampled
    localparam logic [ptrWidth:0] minFree = 3;

    accT mem [`CONV_FIFO_DEPTH];

    logic [ptrWidth-1:0] wrPtrQ;
    logic [ptrWidth-1:0] rdPtrQ;
    logic [ptrWidth:0]   countQ;
    logic [ptrWidth:0]   freeCount;
    logic                pop;

    assign pop       = validOut && readyIn;
    assign validOut  = (countQ != '0);
    assign dataOut   = mem[rdPtrQ];
    assign freeCount = fifoDepth - countQ;
    assign room      = (freeCount >= minFree);

    always_ff @(posedge clkIn) begin
        if (wrValid) begin
            mem[wrPtrQ] <= wrData;
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            wrPtrQ <= '0;
            rdPtrQ <= '0;
            countQ <= '0;
        end else begin
            if (wrValid) begin
                wrPtrQ <= wrPtrQ + 1'b1;
            end
            if (pop) begin
                rdPtrQ <= rdPtrQ + 1'b1;
            end
            case ({wrValid, pop})
                2'b10:   countQ <= countQ + 1'b1;
                2'b01:   countQ <= countQ - 1'b1;
                default: countQ <= countQ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/convAccel.sv ====
`default_nettype none

module convAccel (
    input  wire                            clkIn,
    input  wire                            rstIn,
    input  wire                            startIn,
    input  wire convGeometryPkg::dimT      filtRowsIn,
    input  wire convGeometryPkg::dimT      filtColsIn,
    input  wire convGeometryPkg::dimT      dataRowsIn,
    input  wire convGeometryPkg::dimT      dataColsIn,
    input  wire convGeometryPkg::hostAddrT addrIn,
    input  wire                            wrEnIn,
    input  wire convArithPkg::sampleT      wrDataIn,
    input  wire                            readyIn,
    output logic                           validOut,
    output convArithPkg::accT              dataOut
);
    import convArithPkg::*;

    // Sequencer to memories, memories to MAC
    opReadIf  rdBus ();
    operandIf opBus ();

    logic macValid;
    accT  macResult;
    logic fifoRoom;

    windowSequencer seq0 (
        .clkIn      (clkIn),
        .rstIn      (rstIn),
        .startIn    (startIn),
        .filtRowsIn (filtRowsIn),
        .filtColsIn (filtColsIn),
        .dataRowsIn (dataRowsIn),
        .dataColsIn (dataColsIn),
        .room       (fifoRoom),
        .rd         (rdBus.seq)
    );

    operandStore store0 (
        .clkIn    (clkIn),
        .addrIn   (addrIn),
        .wrEnIn   (wrEnIn),
        .wrDataIn (wrDataIn),
        .rd       (rdBus.store),
        .op       (opBus.src)
    );

    macUnit mac0 (
        .clkIn       (clkIn),
        .rstIn       (rstIn),
        .op          (opBus.sink),
        .resultValid (macValid),
        .result      (macResult)
    );

    // Fullness feeds back to stall address generation
    resultFifo fifo0 (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .wrValid  (macValid),
        .wrData   (macResult),
        .room     (fifoRoom),
        .readyIn  (readyIn),
        .validOut (validOut),
        .dataOut  (dataOut)
    );

endmodule

`default_nettype wire

// ==== bench/clockGen.sv ====
`default_nettype none

// Free-running testbench clock and a synchronous reset pulse
module clockGen #(
    parameter int halfPeriod  = 10,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // Released on a falling edge, away from the DUT's sampling edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/convAccelTb.sv ====
`default_nettype none

`include "convAccel_settings.svh"

module convAccelTb;
    import convGeometryPkg::*;
    import convArithPkg::*;

    // Budget per test is outputs times filter size times 4
    localparam int cycleLimit = (1 * 16 + 36 * 9 + 36 * 9 + 30 * 10) * 4 + 500;
    localparam int patternLen = 256;

    logic     clk;
    logic     rst;
    logic     start;
    dimT      filtRows;
    dimT      filtCols;
    dimT      dataRows;
    dimT      dataCols;
    hostAddrT addr;
    logic     wrEn;
    sampleT   wrData;
    logic     ready = 1'b1;
    logic     validOut;
    accT      dataOut;

    sampleT dataMat [`CONV_MEM_DEPTH];
    sampleT filtMat [`CONV_MEM_DEPTH];
    accT    expected [$];
    bit     readyPattern [patternLen];
    bit     useRandomReady;
    bit     holdPending;
    accT    heldData;
    int     patternIdx;
    int     cycleCount;

    clockGen #(.halfPeriod(10), .resetCycles(3)) clkGen0 (
        .clk (clk),
        .rst (rst)
    );

    convAccel dut0 (
        .clkIn      (clk),
        .rstIn      (rst),
        .startIn    (start),
        .filtRowsIn (filtRows),
        .filtColsIn (filtCols),
        .dataRowsIn (dataRows),
        .dataColsIn (dataCols),
        .addrIn     (addr),
        .wrEnIn     (wrEn),
        .wrDataIn   (wrData),
        .readyIn    (ready),
        .validOut   (validOut),
        .dataOut    (dataOut)
    );

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic writeElement(input logic toFilter, input int index, input sampleT value);
        addr   = {toFilter, elemAddrT'(index)};
        wrEn   = 1'b1;
        wrData = value;
        @(negedge clk);
        wrEn   = 1'b0;
    endtask

    // Random signed contents, written row-major into both memories
    task automatic fillMatrices(input int dRows, input int dCols, input int fRows, input int fCols);
        int i;
        for (i = 0; i < dRows * dCols; i++) begin
            dataMat[i] = sampleT'($urandom_range(0, 65535));
            writeElement(1'b0, i, dataMat[i]);
        end
        for (i = 0; i < fRows * fCols; i++) begin
            filtMat[i] = sampleT'($urandom_range(0, 65535));
            writeElement(1'b1, i, filtMat[i]);
        end
    endtask

    // Valid convolution in raster order, sums wrap at the accumulator width
    task automatic computeExpected(input int dRows, input int dCols, input int fRows,
                                   input int fCols);
        int     oRow;
        int     oCol;
        int     fRow;
        int     fCol;
        longint prod;
        accT    sum;
        for (oRow = 0; oRow <= dRows - fRows; oRow++) begin
            for (oCol = 0; oCol <= dCols - fCols; oCol++) begin
                sum = '0;
                for (fRow = 0; fRow < fRows; fRow++) begin
                    for (fCol = 0; fCol < fCols; fCol++) begin
                        prod = longint'(dataMat[(oRow + fRow) * dCols + oCol + fCol])
                             * longint'(filtMat[fRow * fCols + fCol]);
                        sum  = sum + accT'(prod);
                    end
                end
                expected.push_back(sum);
            end
        end
    endtask

    task automatic runConvolution(input int dRows, input int dCols, input int fRows,
                                  input int fCols, input bit randomReady);
        useRandomReady <= randomReady;
        computeExpected(dRows, dCols, fRows, fCols);
        dataRows = dimT'(dRows);
        dataCols = dimT'(dCols);
        filtRows = dimT'(fRows);
        filtCols = dimT'(fCols);
        start    = 1'b1;
        @(negedge clk);
        start    = 1'b0;
        // Engine works from its latched copy
        dataRows = dimT'(1);
        dataCols = dimT'(1);
        filtRows = dimT'(1);
        filtCols = dimT'(1);
        while (expected.size() != 0) @(posedge clk);
        @(negedge clk);
    endtask

    // Ready drive and output checks share one falling-edge process
    always @(negedge clk) begin
        if (!rst) begin
            if (holdPending) begin
                assert (validOut && dataOut == heldData)
                    else stopOnError($sformatf(
                        "Mismatch at %0t: stalled output changed, held %0d now %0d",
                        $time, heldData, dataOut));
            end
            ready      = useRandomReady ? readyPattern[patternIdx] : 1'b1;
            patternIdx = (patternIdx + 1) % patternLen;
            if (validOut) begin
                assert (expected.size() != 0)
                    else stopOnError("validOut went high with no result left to expect");
                if (ready) begin
                    assert (dataOut == expected[0])
                        else stopOnError($sformatf("Mismatch at %0t: expected %0d, got %0d",
                                                   $time, expected[0], dataOut));
                    void'(expected.pop_front());
                end
            end
            holdPending = validOut && !ready;
            heldData    = dataOut;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            stopOnError($sformatf("Timeout: run did not finish within %0d cycles", cycleLimit));
        end
    end

    initial begin
        int i;
        void'($urandom(49136));
        for (i = 0; i < patternLen; i++) begin
            readyPattern[i] = ($urandom_range(0, 99) < 55);
        end
        start          = 1'b0;
        filtRows       = '0;
        filtCols       = '0;
        dataRows       = '0;
        dataCols       = '0;
        addr           = '0;
        wrEn           = 1'b0;
        wrData         = '0;
        useRandomReady = 1'b0;
        holdPending    = 1'b0;
        heldData       = '0;
        patternIdx     = 0;
        cycleCount     = 0;

        wait (!rst);
        @(negedge clk);
        // Nothing may come out before the first start
        repeat (20) @(negedge clk);

        // Filter covers the whole data matrix
        fillMatrices(4, 4, 4, 4);
        runConvolution(4, 4, 4, 4, 1'b0);
        repeat (10) @(negedge clk);

        fillMatrices(8, 8, 3, 3);
        runConvolution(8, 8, 3, 3, 1'b0);
        repeat (10) @(negedge clk);

        // Same matrices under back-pressure
        runConvolution(8, 8, 3, 3, 1'b1);
        repeat (10) @(negedge clk);

        fillMatrices(6, 10, 2, 5);
        runConvolution(6, 10, 2, 5, 1'b1);

        useRandomReady <= 1'b0;
        repeat (50) @(negedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== convAccel.f ====
+incdir+include
verilog/convGeometryPkg.sv
verilog/convArithPkg.sv
verilog/convIfs.sv
verilog/operandStore.sv
verilog/windowSequencer.sv
verilog/macUnit.sv
verilog/resultFifo.sv
verilog/convAccel.sv
bench/clockGen.sv
bench/convAccelTb.sv

// ==== Bender.yml ====
package:
  name: conv_accel

export_include_dirs:
  - include

sources:
  - verilog/convGeometryPkg.sv
  - verilog/convArithPkg.sv
  - verilog/convIfs.sv
  - verilog/operandStore.sv
  - verilog/windowSequencer.sv
  - verilog/macUnit.sv
  - verilog/resultFifo.sv
  - verilog/convAccel.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/convAccelTb.sv
